// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = WORD_W * LINE_WORDS;
    localparam int WSEL_W     = $clog2(LINE_WORDS);
    localparam int OFFSET_W   = WSEL_W + 2;         // byte offset within a line
    localparam int COUNT_W    = 16;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LINE_W-1:0]  line_t;             // word 0 in low bits
    typedef logic [WSEL_W-1:0]  wsel_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [1:0]         csr_addr_t;

    // register map
    localparam csr_addr_t CSR_CTRL   = 2'd0;        // bit 0 enable, bit 1 flush
    localparam csr_addr_t CSR_HITS   = 2'd1;
    localparam csr_addr_t CSR_MISSES = 2'd2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_RETURN
    } fetch_state_e;

    function automatic word_t line_word(line_t line, wsel_t sel);
        return line[sel*WORD_W +: WORD_W];
    endfunction

endpackage

// ==== rtl/icache_tag.sv ====
`timescale 1ns/100ps

module icache_tag import icache_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  req_i,
    input  addr_t addr_i,
    input  logic  fill_i,
    input  logic  flush_i,
    output logic  hit_o,
    output logic  miss_o
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [NUM_LINES];
    logic [IDX_W-1:0]     addr_idx;
    logic [TAG_W-1:0]     addr_tag;
    logic                 tag_match;

    assign addr_idx = addr_i[OFFSET_W +: IDX_W];
    assign addr_tag = addr_i[ADDR_W-1 -: TAG_W];

    ////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin    // flush beats a same-edge fill
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[addr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[addr_idx] <= addr_tag;            // tag of the refilled line
        end
    end

    // only the indexed line is compared
    assign tag_match = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);

    assign hit_o  = req_i & tag_match;
    assign miss_o = req_i & ~tag_match;

endmodule

// ==== rtl/icache_data.sv ====
`timescale 1ns/100ps

module icache_data import icache_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic  clk_i,
    input  logic  fill_i,
    input  addr_t addr_i,
    input  line_t line_i,
    output word_t rdata_o
);

    localparam int IDX_W = $clog2(NUM_LINES);

    line_t            mem_q [NUM_LINES];
    word_t            rdata_q;
    logic [IDX_W-1:0] addr_idx;
    wsel_t            addr_wsel;

    assign addr_idx  = addr_i[OFFSET_W +: IDX_W];
    assign addr_wsel = addr_i[OFFSET_W-1:2];

    ////////////////////////////////////////////////////////////////////
    // line storage and registered word read
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            mem_q[addr_idx] <= line_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            rdata_q <= line_word(line_i, addr_wsel);          // forward the incoming line
        end else begin
            rdata_q <= line_word(mem_q[addr_idx], addr_wsel);
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/100ps

module icache_ctrl import icache_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  req_i,
    input  addr_t addr_i,
    input  logic  hit_i,
    input  logic  miss_i,
    input  logic  enable_i,
    input  word_t cache_word_i,
    input  logic  mem_valid_i,
    input  line_t mem_line_i,
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    output logic  fill_o,
    output logic  valid_o,
    output word_t rdata_o,
    output logic  hit_evt_o,
    output logic  miss_evt_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic         uncached_q;
    line_t        line_q;
    logic         hit_take;
    logic         miss_take;
    logic         line_done;

    ////////////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////////////
    assign hit_take  = (state_q == ST_IDLE) && enable_i && hit_i;
    assign miss_take = (state_q == ST_IDLE) && req_i && (miss_i || !enable_i);
    assign line_done = (state_q == ST_REFILL) && mem_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (hit_take) begin
                    state_d = ST_RETURN;
                end else if (miss_take) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_valid_i) begin
                    state_d = ST_RETURN;    // line arrives
                end
            end
            ST_RETURN: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            uncached_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (hit_take || miss_take) begin
                uncached_q <= !enable_i;    // held for the whole fetch
            end
        end
    end

    // copy of the memory line for the uncached return
    always_ff @(posedge clk_i) begin
        if (line_done) begin
            line_q <= mem_line_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////
    assign mem_req_o  = (state_q == ST_REFILL);
    assign mem_addr_o = {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign fill_o     = line_done && !uncached_q;

    assign valid_o = (state_q == ST_RETURN);
    assign rdata_o = uncached_q ? line_word(line_q, addr_i[OFFSET_W-1:2]) : cache_word_i;

    assign hit_evt_o  = hit_take;
    assign miss_evt_o = miss_take;

endmodule

// ==== rtl/icache_csr.sv ====
`timescale 1ns/100ps

module icache_csr import icache_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o,
    input  logic      hit_evt_i,
    input  logic      miss_evt_i,
    output logic      enable_o,
    output logic      flush_o
);

    logic   enable_q;
    logic   flush_q;
    count_t hit_cnt_q;
    count_t miss_cnt_q;
    logic   ctrl_we;
    logic   hit_clr;
    logic   miss_clr;

    // saturating event counter where a clear beats an event
    function automatic count_t bump(count_t cnt, logic clr, logic evt);
        if (clr) begin
            return '0;
        end
        if (evt && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    assign ctrl_we  = csr_we_i && (csr_addr_i == CSR_CTRL);
    assign hit_clr  = csr_we_i && (csr_addr_i == CSR_HITS);
    assign miss_clr = csr_we_i && (csr_addr_i == CSR_MISSES);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q   <= 1'b1;
            flush_q    <= 1'b0;
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            flush_q <= ctrl_we && csr_wdata_i[1];      // one cycle pulse
            if (ctrl_we) begin
                enable_q <= csr_wdata_i[0];
            end
            hit_cnt_q  <= bump(hit_cnt_q, hit_clr, hit_evt_i);
            miss_cnt_q <= bump(miss_cnt_q, miss_clr, miss_evt_i);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // register read
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (csr_addr_i)
            CSR_CTRL:   csr_rdata_o = {{(WORD_W-1){1'b0}}, enable_q};   // flush reads 0
            CSR_HITS:   csr_rdata_o = {{(WORD_W-COUNT_W){1'b0}}, hit_cnt_q};
            CSR_MISSES: csr_rdata_o = {{(WORD_W-COUNT_W){1'b0}}, miss_cnt_q};
            default:    csr_rdata_o = '0;
        endcase
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/100ps

module icache_top import icache_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_i,
    input  addr_t     addr_i,
    output word_t     rdata_o,
    output logic      valid_o,
    output logic      mem_req_o,
    output addr_t     mem_addr_o,
    input  logic      mem_valid_i,
    input  line_t     mem_line_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o
);

    logic  tag_req;
    logic  hit;
    logic  miss;
    logic  fill;
    logic  flush;
    logic  enable;
    logic  hit_evt;
    logic  miss_evt;
    word_t cache_word;

    // lookup only while the controller idles
    assign tag_req = req_i & ~mem_req_o & ~valid_o;

    ////////////////////////////////////////////////////////////////////
    // arrays
    ////////////////////////////////////////////////////////////////////
    icache_tag #(
        .NUM_LINES (NUM_LINES)
    ) i_tag (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (tag_req),
        .addr_i  (addr_i),
        .fill_i  (fill),
        .flush_i (flush),
        .hit_o   (hit),
        .miss_o  (miss)
    );

    icache_data #(
        .NUM_LINES (NUM_LINES)
    ) i_data (
        .clk_i   (clk_i),
        .fill_i  (fill),
        .addr_i  (addr_i),
        .line_i  (mem_line_i),
        .rdata_o (cache_word)
    );

    ////////////////////////////////////////////////////////////////////
    // control and registers
    ////////////////////////////////////////////////////////////////////
    icache_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .hit_i        (hit),
        .miss_i       (miss),
        .enable_i     (enable),
        .cache_word_i (cache_word),
        .mem_valid_i  (mem_valid_i),
        .mem_line_i   (mem_line_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .fill_o       (fill),
        .valid_o      (valid_o),
        .rdata_o      (rdata_o),
        .hit_evt_o    (hit_evt),
        .miss_evt_o   (miss_evt)
    );

    icache_csr i_csr (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .hit_evt_i   (hit_evt),
        .miss_evt_i  (miss_evt),
        .enable_o    (enable),
        .flush_o     (flush)
    );

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    logic      clk_i;
    logic      rst_n_i;
    logic      req_i;
    addr_t     addr_i;
    word_t     rdata_o;
    logic      valid_o;
    logic      mem_req_o;
    addr_t     mem_addr_o;
    logic      mem_valid_i;
    line_t     mem_line_i;
    logic      csr_we_i;
    csr_addr_t csr_addr_i;
    word_t     csr_wdata_i;
    word_t     csr_rdata_o;

    logic [7:0] op_q [$];
    word_t      arg_a_q [$];
    word_t      arg_b_q [$];
    count_t     hit_tally;
    count_t     miss_tally;
    int         mem_req_count;
    logic       mem_req_prev;
    int         cycle_count;
    int         cycle_limit;
    integer     mem_seed;

    icache_top #(
        .NUM_LINES (16)
    ) i_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .addr_i      (addr_i),
        .rdata_o     (rdata_o),
        .valid_o     (valid_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////
    // reporting and compares
    ////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                                $time, name, exp, act));
        end
    endtask

    // memory contents follow from the byte address alone
    function automatic word_t expected_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic line_t line_for(addr_t base);
        line_t line;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*WORD_W +: WORD_W] = expected_word(base + 4 * w);
        end
        return line;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // memory model and request counter
    ////////////////////////////////////////////////////////////////////
    initial begin
        int delay;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                check_word("mem_addr_o", {addr_i[31:4], 4'h0}, mem_addr_o);
                delay = 1 + ($unsigned($random(mem_seed)) % 6);   // 1 to 6 cycles
                repeat (delay - 1) @(negedge clk_i);
                mem_line_i  = line_for(mem_addr_o);
                mem_valid_i = 1'b1;
                @(negedge clk_i);
                mem_valid_i = 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        if (mem_req_o && !mem_req_prev) begin
            mem_req_count = mem_req_count + 1;
        end
        mem_req_prev = mem_req_o;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    ////////////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////////////
    task automatic run_fetch(input addr_t addr, input logic exp_miss);
        int waited;
        mem_req_count = 0;
        req_i  = 1'b1;
        addr_i = addr;
        @(negedge clk_i);
        waited = 1;
        while (!valid_o) begin
            @(negedge clk_i);
            waited++;
        end
        check_word("rdata_o", expected_word(addr), rdata_o);
        check_flag("mem_req_o raised", exp_miss, mem_req_count != 0);
        if (!exp_miss) begin
            check_flag("valid_o one cycle after hit", 1'b1, waited == 1);
            hit_tally++;
        end else begin
            miss_tally++;
        end
        req_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic write_reg(input csr_addr_t sel, input word_t data);
        csr_we_i    = 1'b1;
        csr_addr_i  = sel;
        csr_wdata_i = data;
        @(negedge clk_i);
        csr_we_i = 1'b0;
        @(negedge clk_i);               // flush lands one edge later
        if (sel == CSR_HITS) hit_tally = '0;
        if (sel == CSR_MISSES) miss_tally = '0;
    endtask

    task automatic read_reg(input csr_addr_t sel, input word_t exp);
        csr_addr_i = sel;
        @(negedge clk_i);
        check_word("csr_rdata_o", exp, csr_rdata_o);
        if (sel == CSR_HITS) check_count("hit count", hit_tally, csr_rdata_o[15:0]);
        if (sel == CSR_MISSES) check_count("miss count", miss_tally, csr_rdata_o[15:0]);
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        logic [7:0] op;
        word_t      a;
        word_t      b;
        logic       done;
        reg [8*200-1:0] skip_line;
        done = 1'b0;
        fd = $fopen("bench/icache_stim.txt", "r");
        if (fd == 0) abort_run("could not open bench/icache_stim.txt");
        while (!done) begin
            n = $fscanf(fd, " %s", op);
            if (n != 1) abort_run("stimulus file ended without a D line");
            case (op)
                "#": n = $fgets(skip_line, fd);     // comment
                "D": done = 1'b1;
                "F", "W", "R": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) abort_run("stimulus line is missing operands");
                    op_q.push_back(op);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                end
                default: abort_run("unknown opcode in stimulus file");
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        req_i         = 1'b0;
        addr_i        = '0;
        mem_valid_i   = 1'b0;
        mem_line_i    = '0;
        csr_we_i      = 1'b0;
        csr_addr_i    = '0;
        csr_wdata_i   = '0;
        hit_tally     = '0;
        miss_tally    = '0;
        mem_req_count = 0;
        mem_req_prev  = 1'b0;
        cycle_count   = 0;
        cycle_limit   = 0;
        mem_seed      = 68;
        load_stimulus();
        cycle_limit = (op_q.size() + 1) * 20;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "F": run_fetch(arg_a_q[i], arg_b_q[i][0]);
                "W": write_reg(arg_a_q[i][1:0], arg_b_q[i]);
                default: read_reg(arg_a_q[i][1:0], arg_b_q[i]);
            endcase
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== bench/icache_stim.txt ====
# F addr expect_miss | W reg data | R reg expected | D ends the file
# all fields hex, expect_miss is 1 when the fetch must go to memory
F 00001000 1
F 00001004 0
F 00001010 1
F 0000101c 0
F 00002020 1
F 00002028 0
F 00003030 1
F 00004030 1
F 00003034 1
F 00004038 1
W 0 00000003
F 00001008 1
F 0000100c 0
W 0 00000000
R 0 00000000
F 00005040 1
F 00001004 1
F 00005040 1
W 0 00000001
R 0 00000001
F 00005048 1
F 0000504c 0
R 1 00000005
R 2 0000000c
W 1 00000000
W 2 00000000
R 1 00000000
R 2 00000000
D

// ==== sim.f ====
rtl/icache_pkg.sv
rtl/icache_tag.sv
rtl/icache_data.sv
rtl/icache_ctrl.sv
rtl/icache_csr.sv
rtl/icache_top.sv
bench/icache_tb.sv
